/* design/phase_interpolator_emu.sv */
`timescale 1ns/10ps
`default_nettype none

module phase_interpolator_emu
    import pi_emu_pkg::*;
#(
    parameter int HALF_PERIOD  = 1000,
    parameter int DELAY_OFFSET = 20,
    parameter int DELAY_STEP   = 4,
    parameter int DT_MAX       = 250,
    parameter int QUEUE_DEPTH  = 4
)(
    input  wire logic  emu_clk,
    input  wire logic  reset,
    input  wire logic  code_req,
    input  wire code_t code,
    output logic       code_ack,
    output logic       clk_in_val,
    output logic       clk_out_val,
    output dt_t        emu_dt,
    output pm_t        pm_out,
    output logic       pm_valid
);

    logic src_edge;
    logic out_edge;
    logic hold;
    dt_t  src_dt_req;
    dt_t  delay;

    // input clock and its step request
    pi_clock_source #(
        .HALF_PERIOD (HALF_PERIOD),
        .DT_MAX      (DT_MAX)
    ) u_clock_source (
        .emu_clk    (emu_clk),
        .reset      (reset),
        .emu_dt     (emu_dt),
        .hold       (hold),
        .clk_in_val (clk_in_val),
        .src_edge   (src_edge),
        .src_dt_req (src_dt_req)
    );

    pi_code_decoder #(
        .DELAY_OFFSET (DELAY_OFFSET),
        .DELAY_STEP   (DELAY_STEP)
    ) u_code_decoder (
        .emu_clk  (emu_clk),
        .reset    (reset),
        .code_req (code_req),
        .code     (code),
        .code_ack (code_ack),
        .delay    (delay)
    );

    // delay line, also owns the global timestep
    pi_delay_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .DT_MAX      (DT_MAX)
    ) u_delay_core (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .src_edge    (src_edge),
        .clk_in_val  (clk_in_val),
        .src_dt_req  (src_dt_req),
        .delay       (delay),
        .clk_out_val (clk_out_val),
        .out_edge    (out_edge),
        .hold        (hold),
        .emu_dt      (emu_dt)
    );

    pi_phase_monitor u_phase_monitor (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .src_edge    (src_edge),
        .out_edge    (out_edge),
        .clk_in_val  (clk_in_val),
        .clk_out_val (clk_out_val),
        .emu_dt      (emu_dt),
        .pm_out      (pm_out),
        .pm_valid    (pm_valid)
    );

endmodule

`default_nettype wire

/* design/pi_clock_source.sv */
`timescale 1ns/10ps
`default_nettype none

module pi_clock_source
    import pi_emu_pkg::*;
#(
    parameter int HALF_PERIOD = 1000,
    parameter int DT_MAX      = 250
)(
    input  wire logic emu_clk,
    input  wire logic reset,
    input  wire dt_t  emu_dt,
    input  wire logic hold,
    output logic      clk_in_val,
    output logic      src_edge,
    output dt_t       src_dt_req
);

    // emulated time left until the next transition
    dt_t timer;
    logic toggle;

    // the step never exceeds the time to our next edge
    assign src_dt_req = (timer < dt_t'(DT_MAX)) ? timer : dt_t'(DT_MAX);

    // timer consumed by this step, unless the delay queue is full
    assign toggle = !hold && (emu_dt >= timer);

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            timer      <= dt_t'(HALF_PERIOD);
            clk_in_val <= 1'b0;
            src_edge   <= 1'b0;
        end else begin
            src_edge <= toggle;
            if (toggle) begin
                clk_in_val <= ~clk_in_val;
                timer      <= dt_t'(HALF_PERIOD);
            end else if (emu_dt >= timer) begin
                // held off by the queue, edge stays pending
                timer <= '0;
            end else begin
                timer <= timer - emu_dt;
            end
        end
    end

endmodule

`default_nettype wire

/* design/pi_code_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module pi_code_decoder
    import pi_emu_pkg::*;
#(
    parameter int DELAY_OFFSET = 20,
    parameter int DELAY_STEP   = 4
)(
    input  wire logic  emu_clk,
    input  wire logic  reset,
    input  wire logic  code_req,
    input  wire code_t code,
    output logic       code_ack,
    output dt_t        delay
);

    dec_state_t state;
    dt_t        delay_new;

    // linear code to delay mapping
    assign delay_new = dt_t'(DELAY_OFFSET + int'(code) * DELAY_STEP);

    // ack is high in every state except idle
    assign code_ack = (state != IDLE);

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            state <= IDLE;
            delay <= dt_t'(DELAY_OFFSET);
        end else begin
            case (state)
                IDLE: begin
                    // code is stable while req is high, take it now
                    if (code_req) begin
                        state <= ACK;
                        delay <= delay_new;
                    end
                end
                ACK: begin
                    if (!code_req) begin
                        state <= IDLE;
                    end else begin
                        state <= WAIT_LOW;
                    end
                end
                WAIT_LOW: begin
                    if (!code_req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/pi_delay_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pi_delay_core
    import pi_emu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int DT_MAX      = 250
)(
    input  wire logic emu_clk,
    input  wire logic reset,
    input  wire logic src_edge,
    input  wire logic clk_in_val,
    input  wire dt_t  src_dt_req,
    input  wire dt_t  delay,
    output logic      clk_out_val,
    output logic      out_edge,
    output logic      hold,
    output dt_t       emu_dt
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // pending output transitions, remaining time and target level
    dt_t  rem_q [QUEUE_DEPTH];
    logic lvl_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    dt_t  step;

    // freeze the source when its next edge would not fit in the queue
    assign hold = (count == CNT_W'(QUEUE_DEPTH)) ||
                  (src_edge && (count == CNT_W'(QUEUE_DEPTH - 1)));

    // smallest request wins
    always_comb begin
        step = dt_t'(DT_MAX);
        if (!hold && (src_dt_req < step)) begin
            step = src_dt_req;
        end
        if ((count != '0) && (rem_q[rd_ptr] < step)) begin
            step = rem_q[rd_ptr];
        end
        // new entry must not be consumed in the cycle it is written
        if (src_edge && ((delay - 1'b1) < step)) begin
            step = delay - 1'b1;
        end
    end

    assign emu_dt = step;

    assign pop  = (count != '0) && (rem_q[rd_ptr] <= emu_dt);
    assign push = src_edge && ((count != CNT_W'(QUEUE_DEPTH)) || pop);

    // entries age by the global step, this cycle's step included on push
    always_ff @(posedge emu_clk) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            rem_q[i] <= (rem_q[i] > emu_dt) ? rem_q[i] - emu_dt : '0;
        end
        if (push) begin
            rem_q[wr_ptr] <= delay - emu_dt;
            lvl_q[wr_ptr] <= clk_in_val;
        end
    end

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            clk_out_val <= 1'b0;
            out_edge    <= 1'b0;
        end else begin
            out_edge <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                clk_out_val <= lvl_q[rd_ptr];
                rd_ptr      <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/pi_emu_pkg.sv */
`default_nettype none

package pi_emu_pkg;

    // emulated time quantities, one LSB is the smallest time step
    localparam int DT_WIDTH = 16;

    // phase code width, same as the silicon interpolator control word
    localparam int CODE_WIDTH = 9;

    // phase monitor result width
    localparam int PM_WIDTH = 20;

    // unsigned emulated time or timestep
    typedef logic [DT_WIDTH-1:0] dt_t;

    // phase code as delivered over the req/ack interface
    typedef logic [CODE_WIDTH-1:0] code_t;

    // measured edge-to-edge delay, zero-extended from dt_t
    typedef logic [PM_WIDTH-1:0] pm_t;

    // four-phase handshake states of the code decoder
    // IDLE     waiting for a request, ack low
    // ACK      request accepted this cycle, ack high
    // WAIT_LOW ack held until the request drops
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        ACK      = 2'd1,
        WAIT_LOW = 2'd2
    } dec_state_t;

endpackage

`default_nettype wire

/* design/pi_phase_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module pi_phase_monitor
    import pi_emu_pkg::*;
(
    input  wire logic emu_clk,
    input  wire logic reset,
    input  wire logic src_edge,
    input  wire logic out_edge,
    input  wire logic clk_in_val,
    input  wire logic clk_out_val,
    input  wire dt_t  emu_dt,
    output pm_t       pm_out,
    output logic      pm_valid
);

    logic busy;
    logic start;
    logic stop;
    pm_t  acc;

    // edge flags come with the new clock level, so a high level means rising
    assign start = src_edge && clk_in_val;
    assign stop  = busy && out_edge && clk_out_val;

    always_ff @(posedge emu_clk) begin
        if (reset) begin
            busy     <= 1'b0;
            pm_valid <= 1'b0;
        end else begin
            pm_valid <= stop;
            if (stop) begin
                busy <= start;
            end else if (start) begin
                busy <= 1'b1;
            end
        end
    end

    // step of the start cycle counts, step of the stop cycle does not
    always_ff @(posedge emu_clk) begin
        if (stop) begin
            pm_out <= acc;
        end
        if (start && (!busy || stop)) begin
            acc <= pm_t'(emu_dt);
        end else if (busy) begin
            acc <= acc + pm_t'(emu_dt);
        end
    end

endmodule

`default_nettype wire

/* phase_interpolator_emu.f */
design/pi_emu_pkg.sv
design/pi_clock_source.sv
design/pi_code_decoder.sv
design/pi_delay_core.sv
design/pi_phase_monitor.sv
design/phase_interpolator_emu.sv
verif/tb_phase_interpolator_emu.sv

/* verif/tb_phase_interpolator_emu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_phase_interpolator_emu
    import pi_emu_pkg::*;
();

    localparam int HALF_PERIOD  = 1000;
    localparam int DELAY_OFFSET = 20;
    localparam int DELAY_STEP   = 4;
    localparam int DT_MAX       = 250;
    localparam int QUEUE_DEPTH  = 4;
    localparam int NUM_UPDATES  = 8;

    logic  emu_clk;
    logic  reset;
    logic  code_req;
    code_t code;
    logic  code_ack;
    logic  clk_in_val;
    logic  clk_out_val;
    dt_t   emu_dt;
    pm_t   pm_out;
    logic  pm_valid;

    // emulated time reference advanced by the step of every cycle out of reset
    longint      emu_time = 0;
    longint      last_in_time = 0;
    dt_t         dt_cyc = '0;
    logic        req_at_edge = 1'b0;
    logic        req_seen = 1'b0;
    logic        in_prev = 1'b0;
    logic        out_prev = 1'b0;
    int          cur_delay = DELAY_OFFSET;
    int          in_count = 0;
    int          out_count = 0;
    int          pm_checks = 0;
    int          errors = 0;
    longint      exp_out_time [$];
    logic        exp_out_lvl [$];
    int          exp_pm [$];
    logic [31:0] lcg_state;

    phase_interpolator_emu #(
        .HALF_PERIOD  (HALF_PERIOD),
        .DELAY_OFFSET (DELAY_OFFSET),
        .DELAY_STEP   (DELAY_STEP),
        .DT_MAX       (DT_MAX),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) u_dut (
        .emu_clk     (emu_clk),
        .reset       (reset),
        .code_req    (code_req),
        .code        (code),
        .code_ack    (code_ack),
        .clk_in_val  (clk_in_val),
        .clk_out_val (clk_out_val),
        .emu_dt      (emu_dt),
        .pm_out      (pm_out),
        .pm_valid    (pm_valid)
    );

    initial begin
        emu_clk = 1'b0;
        forever begin
            #50 emu_clk = ~emu_clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic finish_run();
        $display("errors %0d, input transitions %0d, output transitions %0d, pm results %0d",
                 errors, in_count, out_count, pm_checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(negedge emu_clk);
            n++;
        end while ((code_ack !== level) && (n < 20));
        if (code_ack !== level) begin
            errors++;
            $display("code_ack did not go to %0b within 20 cycles", level);
            finish_run();
        end
    endtask

    task automatic wait_in_edges(input int num);
        int target;
        int n;
        target = in_count + num;
        n = 0;
        while ((in_count < target) && (n < num * 20 + 50)) begin
            @(negedge emu_clk);
            n++;
        end
        if (in_count < target) begin
            errors++;
            $display("clk_in_val stopped toggling, %0d transitions missing", target - in_count);
            finish_run();
        end
    endtask

    // four-phase update that leaves the code in place until the next request
    task automatic handshake_code(input code_t value);
        code = value;
        code_req = 1'b1;
        wait_ack(1'b1);
        code_req = 1'b0;
        wait_ack(1'b0);
    endtask

    always @(posedge emu_clk) begin
        req_at_edge <= code_req;
        if (!reset) begin
            emu_time <= emu_time + longint'(dt_cyc);
        end
    end

    // mid-cycle checks on settled outputs
    always @(negedge emu_clk) begin
        dt_cyc = emu_dt;
        assert ((emu_dt != '0) && (emu_dt <= dt_t'(DT_MAX))) else begin
            errors++;
            $display("Fail step_bound expected 1..%0d actual %0d", DT_MAX, emu_dt);
        end
        // ack follows the request level seen at the last edge
        assert (code_ack == req_at_edge) else begin
            errors++;
            $display("Fail handshake expected %0b actual %0b", req_at_edge, code_ack);
        end
        // an accepted request makes the new delay live from this cycle on
        if (req_at_edge && !req_seen) begin
            cur_delay = DELAY_OFFSET + int'(code) * DELAY_STEP;
        end
        if (clk_in_val != in_prev) begin
            assert (emu_time - last_in_time == HALF_PERIOD) else begin
                errors++;
                $display("Fail half_period expected %0d actual %0d",
                         HALF_PERIOD, emu_time - last_in_time);
            end
            last_in_time = emu_time;
            in_count++;
            exp_out_time.push_back(emu_time + cur_delay);
            exp_out_lvl.push_back(clk_in_val);
            if (clk_in_val) begin
                // the previous measurement ends well inside one input period
                assert (exp_pm.size() == 0) else begin
                    errors++;
                    $display("no phase monitor result for the previous rising input edge");
                    exp_pm.delete();
                end
                exp_pm.push_back(cur_delay);
            end
        end
        if (clk_out_val != out_prev) begin
            out_count++;
            if (exp_out_time.size() == 0) begin
                errors++;
                $display("clk_out_val changed with no input transition pending");
            end else begin
                assert (emu_time == exp_out_time[0]) else begin
                    errors++;
                    $display("Fail out_time expected %0d actual %0d", exp_out_time[0], emu_time);
                end
                assert (clk_out_val == exp_out_lvl[0]) else begin
                    errors++;
                    $display("Fail out_level expected %0b actual %0b",
                             exp_out_lvl[0], clk_out_val);
                end
                void'(exp_out_time.pop_front());
                void'(exp_out_lvl.pop_front());
            end
        end
        assert ((in_count >= out_count) && (in_count - out_count <= QUEUE_DEPTH)) else begin
            errors++;
            $display("input and output transition counts drifted apart, %0d against %0d",
                     in_count, out_count);
        end
        if (pm_valid) begin
            pm_checks++;
            if (exp_pm.size() == 0) begin
                errors++;
                $display("pm_valid pulsed with no rising input edge pending");
            end else begin
                assert (pm_out == pm_t'(exp_pm[0])) else begin
                    errors++;
                    $display("Fail phase_monitor expected %0d actual %0d", exp_pm[0], pm_out);
                end
                void'(exp_pm.pop_front());
            end
        end
        in_prev = clk_in_val;
        out_prev = clk_out_val;
        req_seen = req_at_edge;
    end

    initial begin
        int wait_cycles;
        reset = 1'b1;
        code_req = 1'b0;
        code = '0;
        lcg_state = 32'd66;
        repeat (5) @(negedge emu_clk);
        reset = 1'b0;
        @(negedge emu_clk);
        assert (!clk_in_val && !clk_out_val && !code_ack && !pm_valid &&
                (emu_dt <= dt_t'(DT_MAX))) else begin
            errors++;
            $display("outputs are not in their reset state after reset");
        end
        // free running with code 0 from reset
        wait_in_edges(8);
        for (int i = 0; i < NUM_UPDATES; i++) begin
            lcg_state = lcg_step(lcg_state);
            handshake_code(code_t'((lcg_state >> 16) % 201));
            lcg_state = lcg_step(lcg_state);
            wait_cycles = int'((lcg_state >> 16) % 16);
            repeat (wait_cycles) @(negedge emu_clk);
            wait_in_edges(6);
        end
        if ((pm_checks == 0) || (out_count == 0)) begin
            errors++;
            $display("no output transitions or phase monitor results were seen");
        end
        finish_run();
    end

endmodule

`default_nettype wire
